//--- vlog.f
arith_pkg.sv
iter_counter.sv
op_ctrl.sv
div_datapath.sv
mult_pipe.sv
apb_regs.sv
arith_unit.sv
tb_arith_unit.sv

//--- tb_arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arith_unit;

  // A full division costs OPERAND_W + 12 cycles of APB traffic
  localparam int TIMEOUT_CYCLES = 30 * (arith_pkg::OPERAND_W + 12) + 100;

  logic                clk;
  logic                rst_n;
  arith_pkg::apb_req_t apb_req;
  arith_pkg::apb_rsp_t apb_rsp;
  logic [15:0]         lfsr_state;
  int                  err_count = 0;
  int                  check_count = 0;
  int                  cycle_count = 0;

  arith_unit arith_unit_i (.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_operand(output arith_pkg::operand_t v);
    v = '0;
    for (int i = 0; i < arith_pkg::OPERAND_W; i++) begin
      v = {v[arith_pkg::OPERAND_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Quotient truncates toward zero
  function automatic arith_pkg::operand_t ref_quotient(input arith_pkg::operand_t a,
                                                       input arith_pkg::operand_t b);
    int ia;
    int ib;
    int q;
    ia = a;
    ib = b;
    if (ia == 0) return '0;
    q = (ia < 0 ? -ia : ia) / (ib < 0 ? -ib : ib);
    if ((ia < 0) != (ib < 0)) q = -q;
    return arith_pkg::operand_t'(q);
  endfunction

  function automatic arith_pkg::operand_t ref_remainder(input arith_pkg::operand_t a,
                                                        input arith_pkg::operand_t b);
    int ia;
    int ib;
    int mb;
    int t0;
    int t1;
    ia = a;
    ib = b;
    if (ia == 0) return '0;
    mb = ib < 0 ? -ib : ib;
    t0 = (ia < 0 ? -ia : ia) % mb;
    t1 = ((ia < 0) != (ib < 0) && t0 != 0) ? mb - t0 : t0;
    return arith_pkg::operand_t'(ib < 0 ? -t1 : t1);
  endfunction

  function automatic arith_pkg::operand_t ref_product(input arith_pkg::operand_t a,
                                                      input arith_pkg::operand_t b);
    int ia;
    int ib;
    ia = a;
    ib = b;
    return arith_pkg::operand_t'(ia * ib);
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Called 1 ns after a rising edge; returns 1 ns after the completing edge
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #4;
    while (!apb_rsp.pready) begin
      @(posedge clk);
      #5;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic launch_op(input arith_pkg::op_e op, input arith_pkg::operand_t a,
                           input arith_pkg::operand_t b);
    logic [31:0] ctrl;
    logic        err;
    apb_write(arith_pkg::ADDR_A, a, err);
    apb_write(arith_pkg::ADDR_B, b, err);
    ctrl = '0;
    ctrl[arith_pkg::CTRL_START_BIT] = 1'b1;
    ctrl[arith_pkg::CTRL_OP_BIT]    = op;
    apb_write(arith_pkg::ADDR_CTRL, ctrl, err);
    expect_equal("pslverr on idle start", {31'b0, err}, 32'd0);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    do apb_read(arith_pkg::ADDR_STATUS, st);
    while (!st[arith_pkg::STATUS_DONE_BIT]);
    expect_equal("STATUS at completion", st, 32'd1 << arith_pkg::STATUS_DONE_BIT);
  endtask

  task automatic check_results(input arith_pkg::operand_t exp_res,
                               input arith_pkg::operand_t exp_rem);
    logic [31:0] rd;
    int          e;
    apb_read(arith_pkg::ADDR_RES, rd);
    e = exp_res;
    expect_equal("RES", rd, e);
    apb_read(arith_pkg::ADDR_REM, rd);
    e = exp_rem;
    expect_equal("REM", rd, e);
  endtask

  task automatic run_division(input arith_pkg::operand_t a, input arith_pkg::operand_t b);
    logic [31:0] st;
    launch_op(arith_pkg::OP_DIV, a, b);
    apb_read(arith_pkg::ADDR_STATUS, st);
    expect_equal("STATUS while dividing", st, 32'd1 << arith_pkg::STATUS_BUSY_BIT);
    wait_done();
    check_results(ref_quotient(a, b), ref_remainder(a, b));
  endtask

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    arith_pkg::operand_t a;
    arith_pkg::operand_t b;
    logic [31:0]         rd;
    logic                err;
    int                  wait_cycles;
    apb_req    = '0;
    rst_n      = 1'b0;
    lfsr_state = 16'd50834;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    apb_read(arith_pkg::ADDR_STATUS, rd);
    expect_equal("STATUS after reset", rd, 32'd0);
    apb_read(arith_pkg::ADDR_RES, rd);
    expect_equal("RES after reset", rd, 32'd0);
    apb_read(arith_pkg::ADDR_REM, rd);
    expect_equal("REM after reset", rd, 32'd0);
    apb_write(arith_pkg::ADDR_A, 32'hFFFF_8123, err);
    apb_write(arith_pkg::ADDR_B, 32'h0000_1234, err);
    apb_read(arith_pkg::ADDR_A, rd);
    expect_equal("A readback", rd, 32'hFFFF_8123);
    apb_read(arith_pkg::ADDR_B, rd);
    expect_equal("B readback", rd, 32'h0000_1234);

    for (int i = 0; i < 20; i++) begin
      rand_operand(a);
      rand_operand(b);
      if (b == '0) b = 1;
      run_division(a, b);
    end
    run_division('0, -16'sd7);

    // Start while busy is refused and new operands do not disturb the division
    launch_op(arith_pkg::OP_DIV, -16'sd1000, 16'sd37);
    apb_write(arith_pkg::ADDR_A, 32'd555, err);
    apb_write(arith_pkg::ADDR_CTRL, 32'h3, err);
    expect_equal("pslverr on busy start", {31'b0, err}, 32'd1);
    wait_done();
    check_results(ref_quotient(-16'sd1000, 16'sd37), ref_remainder(-16'sd1000, 16'sd37));

    // done registers MULT_STAGES edges after the start write completes
    for (int i = 0; i < 6; i++) begin
      rand_operand(a);
      rand_operand(b);
      launch_op(arith_pkg::OP_MUL, a, b);
      wait_cycles = arith_pkg::MULT_STAGES - 1 - (i % 2);
      repeat (wait_cycles) begin
        @(posedge clk);
        #1;
      end
      apb_read(arith_pkg::ADDR_STATUS, rd);
      if (wait_cycles == arith_pkg::MULT_STAGES - 1)
        expect_equal("STATUS at product time", rd, 32'd1 << arith_pkg::STATUS_DONE_BIT);
      else
        expect_equal("STATUS before product", rd, 32'd1 << arith_pkg::STATUS_BUSY_BIT);
      wait_done();
      check_results(ref_product(a, b), '0);
    end

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  arith_pkg::apb_req_t apb_req,
  output arith_pkg::apb_rsp_t apb_rsp
);

  logic                 busy;
  logic                 done;
  logic                 start;
  logic                 div_load;
  logic                 div_step;
  logic                 cnt_load;
  logic                 div_done;
  logic                 last;
  logic                 zero_dividend;
  logic                 mul_valid_in;
  logic                 mul_valid_out;
  arith_pkg::calc_req_t calc_req;
  arith_pkg::div_res_t  div_res;
  arith_pkg::operand_t  product;

  apb_regs apb_regs_i (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .busy(busy), .done(done), .start(start), .calc_req(calc_req),
    .div_done(div_done), .div_res(div_res),
    .mul_valid_out(mul_valid_out), .product(product)
  );

  op_ctrl op_ctrl_i (
    .clk(clk), .rst_n(rst_n), .start(start), .op(calc_req.op),
    .zero_dividend(zero_dividend), .last(last), .mul_valid_out(mul_valid_out),
    .div_load(div_load), .div_step(div_step), .cnt_load(cnt_load),
    .mul_valid_in(mul_valid_in), .div_done(div_done), .busy(busy), .done(done)
  );

  iter_counter iter_counter_i (
    .clk(clk), .rst_n(rst_n), .load(cnt_load), .step(div_step), .last(last)
  );

  div_datapath div_datapath_i (
    .clk(clk), .rst_n(rst_n), .load(div_load), .step(div_step), .req(calc_req),
    .zero_dividend(zero_dividend), .res(div_res)
  );

  mult_pipe mult_pipe_i (
    .clk(clk), .rst_n(rst_n), .valid_in(mul_valid_in), .a(calc_req.a), .b(calc_req.b),
    .valid_out(mul_valid_out), .product(product)
  );

endmodule

`default_nettype wire

//--- apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  arith_pkg::apb_req_t  apb_req,
  output arith_pkg::apb_rsp_t  apb_rsp,
  input  logic                 busy,
  input  logic                 done,
  output logic                 start,
  output arith_pkg::calc_req_t calc_req,
  input  logic                 div_done,
  input  arith_pkg::div_res_t  div_res,
  input  logic                 mul_valid_out,
  input  arith_pkg::operand_t  product
);

  arith_pkg::operand_t       a_q;
  arith_pkg::operand_t       b_q;
  arith_pkg::op_e            op_q;
  arith_pkg::op_e            wr_op;
  arith_pkg::operand_t       res_q;
  arith_pkg::operand_t       rem_q;
  logic                      access;
  logic                      wr;
  logic                      rd;
  logic                      ctrl_wr;
  logic                      start_req;
  logic                      slv_err;
  logic                      ctrl_ok;
  logic [arith_pkg::APB_DW-1:0] rdata;

  function automatic logic [arith_pkg::APB_DW-1:0] sext(arith_pkg::operand_t v);
    return {{(arith_pkg::APB_DW - arith_pkg::OPERAND_W){v[arith_pkg::OPERAND_W-1]}}, v};
  endfunction

  // Access phase of a transfer; pready is tied high
  assign access = apb_req.psel && apb_req.penable;
  assign wr     = access && apb_req.pwrite;
  assign rd     = access && !apb_req.pwrite;

  assign ctrl_wr   = wr && (apb_req.paddr == arith_pkg::ADDR_CTRL);
  assign start_req = ctrl_wr && apb_req.pwdata[arith_pkg::CTRL_START_BIT];
  assign slv_err   = start_req && busy;
  assign ctrl_ok   = ctrl_wr && !slv_err;
  assign start     = start_req && !busy;

  assign wr_op = arith_pkg::op_e'(apb_req.pwdata[arith_pkg::CTRL_OP_BIT]);

  // Op comes straight from the start write itself
  always_comb begin
    calc_req.op = ctrl_ok ? wr_op : op_q;
    calc_req.a  = a_q;
    calc_req.b  = b_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      op_q  <= arith_pkg::OP_DIV;
      res_q <= '0;
      rem_q <= '0;
    end else begin
      if (wr && (apb_req.paddr == arith_pkg::ADDR_A)) begin
        a_q <= apb_req.pwdata[arith_pkg::OPERAND_W-1:0];
      end
      if (wr && (apb_req.paddr == arith_pkg::ADDR_B)) begin
        b_q <= apb_req.pwdata[arith_pkg::OPERAND_W-1:0];
      end
      if (ctrl_ok) begin
        op_q <= wr_op;
      end
      // Only one operation is in flight, so the captures never collide
      if (div_done) begin
        res_q <= div_res.quotient;
        rem_q <= div_res.remainder;
      end else if (mul_valid_out) begin
        res_q <= product;
        rem_q <= '0;
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (rd) begin
      case (apb_req.paddr)
        arith_pkg::ADDR_A:    rdata = sext(a_q);
        arith_pkg::ADDR_B:    rdata = sext(b_q);
        arith_pkg::ADDR_CTRL: rdata[arith_pkg::CTRL_OP_BIT] = op_q;
        arith_pkg::ADDR_STATUS: begin
          rdata[arith_pkg::STATUS_BUSY_BIT] = busy;
          rdata[arith_pkg::STATUS_DONE_BIT] = done;
        end
        arith_pkg::ADDR_RES:  rdata = sext(res_q);
        arith_pkg::ADDR_REM:  rdata = sext(rem_q);
        default:              rdata = '0;
      endcase
    end
  end

  always_comb begin
    apb_rsp.prdata  = rdata;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = slv_err;
  end

endmodule

`default_nettype wire

//--- mult_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mult_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_in,
  input  arith_pkg::operand_t a,
  input  arith_pkg::operand_t b,
  output logic                valid_out,
  output arith_pkg::operand_t product
);

  arith_pkg::operand_t                    a_s1;
  arith_pkg::operand_t                    b_s1;
  logic signed [2*arith_pkg::OPERAND_W-1:0] full_s2;
  arith_pkg::operand_t                    prod_s3;
  logic [arith_pkg::MULT_STAGES-1:0]      valid_sr;

  // Data advances every cycle, no stall
  always_ff @(posedge clk) begin
    a_s1    <= a;
    b_s1    <= b;
    // Operands are sign extended to the full product width
    full_s2 <= a_s1 * b_s1;
    prod_s3 <= full_s2[arith_pkg::OPERAND_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[arith_pkg::MULT_STAGES-2:0], valid_in};
    end
  end

  assign valid_out = valid_sr[arith_pkg::MULT_STAGES-1];
  assign product   = prod_s3;

endmodule

`default_nettype wire

//--- div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 step,
  input  arith_pkg::calc_req_t req,
  output logic                 zero_dividend,
  output arith_pkg::div_res_t  res
);

  logic                            a_neg;
  logic                            b_neg;
  logic                            diff_sign;
  logic [arith_pkg::OPERAND_W-1:0] a_mag;
  logic [arith_pkg::OPERAND_W-1:0] b_mag;
  logic [arith_pkg::OPERAND_W-1:0] divisor;
  logic [arith_pkg::OPERAND_W-1:0] acc;
  logic [arith_pkg::OPERAND_W-1:0] quo;
  logic [arith_pkg::OPERAND_W:0]   trial;
  logic                            fits;
  logic [arith_pkg::OPERAND_W-1:0] t0;
  logic [arith_pkg::OPERAND_W-1:0] t1;

  // Magnitudes; the most negative value maps to 2^(W-1) as unsigned
  assign a_mag = req.a[arith_pkg::OPERAND_W-1] ? -req.a : req.a;
  assign b_mag = req.b[arith_pkg::OPERAND_W-1] ? -req.b : req.b;

  // Shift the next dividend bit into the partial remainder
  assign trial = {acc, quo[arith_pkg::OPERAND_W-1]};
  assign fits  = (trial >= {1'b0, divisor});

  always_ff @(posedge clk) begin
    if (load) begin
      a_neg   <= req.a[arith_pkg::OPERAND_W-1];
      b_neg   <= req.b[arith_pkg::OPERAND_W-1];
      divisor <= b_mag;
      acc     <= '0;
      quo     <= a_mag;
    end else if (step) begin
      // Difference is below the divisor, so the low bits hold it exactly
      if (fits) begin
        acc <= trial[arith_pkg::OPERAND_W-1:0] - divisor;
      end else begin
        acc <= trial[arith_pkg::OPERAND_W-1:0];
      end
      quo <= {quo[arith_pkg::OPERAND_W-2:0], fits};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      zero_dividend <= 1'b0;
    end else begin
      zero_dividend <= load && (req.a == '0);
    end
  end

  assign diff_sign = a_neg ^ b_neg;

  // Remainder takes the sign of the divisor
  assign t0 = acc;
  assign t1 = (diff_sign && (t0 != '0)) ? divisor - t0 : t0;

  always_comb begin
    res.quotient  = diff_sign ? -quo : quo;
    res.remainder = b_neg ? -t1 : t1;
  end

endmodule

`default_nettype wire

//--- op_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module op_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  arith_pkg::op_e  op,
  input  logic            zero_dividend,
  input  logic            last,
  input  logic            mul_valid_out,
  output logic            div_load,
  output logic            div_step,
  output logic            cnt_load,
  output logic            mul_valid_in,
  output logic            div_done,
  output logic            busy,
  output logic            done
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RUN_DIV = 2'd1,
    RUN_MUL = 2'd2
  } state_e;

  state_e state;
  logic   accept;
  logic   finish_div;
  logic   finish_mul;
  logic   complete;

  assign accept = start && (state == IDLE);

  // Launch pulses go out in the same cycle as the accepted start
  assign div_load     = accept && (op == arith_pkg::OP_DIV);
  assign cnt_load     = accept && (op == arith_pkg::OP_DIV);
  assign mul_valid_in = accept && (op == arith_pkg::OP_MUL);

  // No iterations at all for a zero dividend
  assign div_step   = (state == RUN_DIV) && !zero_dividend;
  assign finish_div = (state == RUN_DIV) && (last || zero_dividend);
  assign finish_mul = (state == RUN_MUL) && mul_valid_out;

  // Division result is final one cycle after its last step
  assign complete = div_done || finish_mul;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      div_done <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end else begin
      div_done <= finish_div;
      case (state)
        IDLE: begin
          if (div_load) begin
            state <= RUN_DIV;
          end else if (mul_valid_in) begin
            state <= RUN_MUL;
          end
        end
        RUN_DIV: if (finish_div) state <= IDLE;
        RUN_MUL: if (finish_mul) state <= IDLE;
        default: state <= IDLE;
      endcase
      // Busy spans the div_done cycle too, so no start slips in there
      if (accept) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (complete) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- iter_counter.sv
`timescale 1ns/1ps
`default_nettype none

module iter_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  // One spare bit so the full iteration count fits
  typedef logic [$clog2(arith_pkg::OPERAND_W):0] cnt_t;

  cnt_t count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= cnt_t'(arith_pkg::OPERAND_W);
    end else if (step) begin
      count <= count - cnt_t'(1);
    end
  end

  // Final iteration is the one taken while the count is one
  assign last = (count == cnt_t'(1));

endmodule

`default_nettype wire

//--- arith_pkg.sv
`default_nettype none

package arith_pkg;

  localparam int OPERAND_W   = 16;
  localparam int APB_AW      = 8;
  localparam int APB_DW      = 32;
  localparam int MULT_STAGES = 3;

  // Register map
  localparam logic [APB_AW-1:0] ADDR_A      = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_B      = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;
  localparam logic [APB_AW-1:0] ADDR_RES    = 8'h10;
  localparam logic [APB_AW-1:0] ADDR_REM    = 8'h14;

  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_OP_BIT     = 1;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  typedef logic signed [OPERAND_W-1:0] operand_t;

  typedef enum logic {
    OP_DIV = 1'b0,
    OP_MUL = 1'b1
  } op_e;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    op_e      op;
    operand_t a;
    operand_t b;
  } calc_req_t;

  typedef struct packed {
    operand_t quotient;
    operand_t remainder;
  } div_res_t;

endpackage

`default_nettype wire
